// File: Makefile
# Verilator build and run for the address arithmetic testbench
VERILATOR ?= verilator
TOP       ?= tb_mac_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails on a nonzero exit or on the fail message in the log
run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
rtl/mac_cfg_pkg.sv
rtl/mac_instr_pkg.sv
rtl/mac_req_if.sv
rtl/mac_fastadd.sv
rtl/mac_decode.sv
rtl/mac_regs.sv
rtl/mac_addr_pipe.sv
rtl/mac_top.sv
sim/mac_assertions.sv
sim/tb_mac_top.sv

// File: rtl/mac_addr_pipe.sv
`timescale 1ns/100ps

// Effective address in two stages
// Stage 1 picks the base (B+X through the first adder)
// Stage 2 adds the sign extended displacement
module mac_addr_pipe (
  input  logic                           clk,
  input  logic                           rst_n,
  mac_req_if.pipe                        req,
  input  logic [mac_cfg_pkg::addr_w-1:0] p,
  input  logic [mac_cfg_pkg::addr_w-1:0] b,
  input  logic [mac_cfg_pkg::addr_w-1:0] x,
  output logic                           addr_valid,
  output logic [mac_cfg_pkg::addr_w-1:0] addr
);

  localparam int bw = mac_cfg_pkg::byte_w;
  localparam int aw = mac_cfg_pkg::addr_w;

  logic [aw-1:0] bx_sum;    // B plus X
  logic [aw-1:0] base_sel;  // Mode selected base

  logic          s1_valid;
  logic [aw-1:0] s1_base;
  logic [bw-1:0] s1_disp;

  logic [bw-1:0] disp_ext;  // Upper byte of the sign extension
  logic [aw-1:0] ea_sum;

  // First adder, X split into halves on top of B
  mac_fastadd u_add_bx (
    .lo   (x[bw-1:0]),
    .hi   (x[aw-1:bw]),
    .base (b),
    .sum  (bx_sum)
  );

  // Base by mode bits
  always_comb begin
    case ({req.use_x, req.use_b})
      2'b01:   base_sel = b;       // Base only
      2'b10:   base_sel = x;       // Index only
      2'b11:   base_sel = bx_sum;  // Both
      default: base_sel = p;       // Neither, relative to P
    endcase
  end

  // Stage 1 control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req.valid;
    end
  end

  // Stage 1 payload, only loaded on a request
  always_ff @(posedge clk) begin
    if (req.valid) begin
      s1_base <= base_sel;
      s1_disp <= req.disp;
    end
  end

  // All ones for a negative displacement
  assign disp_ext = {bw{s1_disp[bw-1]}};

  // Second adder, displacement onto the registered base
  mac_fastadd u_add_disp (
    .lo   (s1_disp),
    .hi   (disp_ext),
    .base (s1_base),
    .sum  (ea_sum)
  );

  // Stage 2 control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_valid <= 1'b0;
    end else begin
      addr_valid <= s1_valid;  // Two edges after req.valid
    end
  end

  // Stage 2 payload, not held past the strobe
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      addr <= ea_sum;
    end
  end

endmodule

// File: rtl/mac_cfg_pkg.sv
package mac_cfg_pkg;

  // Datapath widths
  localparam int addr_w = 16;  // Address and register width
  localparam int byte_w = 8;   // Adder half, displacement, immediate
  localparam int op_w   = 5;   // Opcode field

  // Opcode map
  // Everything from zero up to op_mem_max is a memory reference
  localparam logic [op_w-1:0] op_mem_max = 5'b01111;
  localparam logic [op_w-1:0] op_ldreg   = 5'b10000;  // Byte load into P, B or X

  // Register select codes in the load format
  localparam logic [1:0] reg_p    = 2'd0;  // Program counter
  localparam logic [1:0] reg_b    = 2'd1;  // Base
  localparam logic [1:0] reg_x    = 2'd2;  // Index
  localparam logic [1:0] reg_none = 2'd3;  // No target, load is dropped

  // Register file depth, P B X
  localparam int reg_cnt = 3;

endpackage

// File: rtl/mac_decode.sv
`timescale 1ns/100ps

// Instruction classifier
// Memory references go to the pipeline, byte loads to the register file
module mac_decode (
  input  logic                           instr_valid,
  input  mac_instr_pkg::instr_u          instr,
  mac_req_if.dec                         req,
  output logic                           wr_en,    // Register byte write
  output logic [1:0]                     wr_sel,   // P, B or X
  output logic                           wr_hi,    // Upper byte lane
  output logic [mac_cfg_pkg::byte_w-1:0] wr_data
);

  logic [mac_cfg_pkg::op_w-1:0] op;  // Shared opcode bits
  logic                         is_mem;
  logic                         is_ld;

  assign op = instr.mem.op;  // Same bits as instr.regld.op

  // Opcode classes
  assign is_mem = (op <= mac_cfg_pkg::op_mem_max);
  assign is_ld  = (op == mac_cfg_pkg::op_ldreg) &&
                  (instr.regld.sel != mac_cfg_pkg::reg_none);  // reg_none drops the load

  // Request to the address pipeline
  always_comb begin
    req.valid = instr_valid && is_mem;
    req.use_b = instr.mem.b;     // Payload passes through regardless of valid
    req.use_x = instr.mem.x;
    req.disp  = instr.mem.disp;  // Sign extension done downstream
  end

  // Register load, lands on the next edge
  always_comb begin
    wr_en   = instr_valid && is_ld;
    wr_sel  = instr.regld.sel;
    wr_hi   = instr.regld.hi;
    wr_data = instr.regld.imm;
  end

  // Other opcodes fall through with both strobes low

endmodule

// File: rtl/mac_fastadd.sv
`timescale 1ns/100ps

// 16-bit add from two 8-bit halves
// Low half carries into the high half, final carry dropped
module mac_fastadd (
  input  logic [mac_cfg_pkg::byte_w-1:0] lo,    // Added to base[7:0]
  input  logic [mac_cfg_pkg::byte_w-1:0] hi,    // Added to base[15:8]
  input  logic [mac_cfg_pkg::addr_w-1:0] base,
  output logic [mac_cfg_pkg::addr_w-1:0] sum
);

  localparam int bw = mac_cfg_pkg::byte_w;

  logic [bw:0]   lo_sum;    // Low half with carry out on top
  logic          carry_lo;  // Into the high half
  logic [bw-1:0] hi_sum;

  // Low half, zero carry in
  assign lo_sum   = {1'b0, lo} + {1'b0, base[bw-1:0]};
  assign carry_lo = lo_sum[bw];

  // High half, carry out is discarded so the sum wraps
  assign hi_sum = hi + base[2*bw-1:bw] + {{(bw-1){1'b0}}, carry_lo};

  assign sum = {hi_sum, lo_sum[bw-1:0]};

endmodule

// File: rtl/mac_instr_pkg.sv
package mac_instr_pkg;

  // Memory reference format
  // Base picked by x and b, i is indirect and not handled here
  typedef struct packed {
    logic [mac_cfg_pkg::op_w-1:0]   op;    // Opcode, 0 to op_mem_max
    logic                           x;     // Add index register
    logic                           i;     // Indirect, decoded but ignored
    logic                           b;     // Add base register
    logic [mac_cfg_pkg::byte_w-1:0] disp;  // Signed displacement
  } mem_fmt_t;

  // Register load format
  typedef struct packed {
    logic [mac_cfg_pkg::op_w-1:0]   op;   // Opcode, op_ldreg
    logic [1:0]                     sel;  // Target register select
    logic                           hi;   // 1 for upper byte
    logic [mac_cfg_pkg::byte_w-1:0] imm;  // Byte written
  } reg_fmt_t;

  // Same 16-bit word, two readings
  // Opcode sits in the same five bits in both views
  typedef union packed {
    mem_fmt_t mem;    // Memory reference view
    reg_fmt_t regld;  // Register load view
  } instr_u;

endpackage

// File: rtl/mac_regs.sv
`timescale 1ns/100ps

// P, B and X with byte lane writes
module mac_regs (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wr_en,
  input  logic [1:0]                     wr_sel,   // reg_p, reg_b, reg_x
  input  logic                           wr_hi,    // 1 writes bits 15:8
  input  logic [mac_cfg_pkg::byte_w-1:0] wr_data,
  output logic [mac_cfg_pkg::addr_w-1:0] p,
  output logic [mac_cfg_pkg::addr_w-1:0] b,
  output logic [mac_cfg_pkg::addr_w-1:0] x
);

  localparam int bw = mac_cfg_pkg::byte_w;
  localparam int aw = mac_cfg_pkg::addr_w;
  localparam int rc = mac_cfg_pkg::reg_cnt;

  logic [aw-1:0] rf [0:rc-1];  // Indexed by select code

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < rc; i++) begin
        rf[i] <= '0;  // All three cleared
      end
    end else if (wr_en && (wr_sel != mac_cfg_pkg::reg_none)) begin
      if (wr_hi) begin
        rf[wr_sel][2*bw-1:bw] <= wr_data;  // Upper byte only
      end else begin
        rf[wr_sel][bw-1:0] <= wr_data;     // Lower byte only
      end
    end
  end

  // Named views for the pipeline
  assign p = rf[mac_cfg_pkg::reg_p];
  assign b = rf[mac_cfg_pkg::reg_b];
  assign x = rf[mac_cfg_pkg::reg_x];

endmodule

// File: rtl/mac_req_if.sv
`timescale 1ns/100ps

// Decoded address request, decoder to address pipeline
// valid is a one cycle strobe, nothing pushes back
interface mac_req_if;

  logic                           valid;  // Memory reference this cycle
  logic                           use_b;  // Base register in the sum
  logic                           use_x;  // Index register in the sum
  logic [mac_cfg_pkg::byte_w-1:0] disp;   // Raw displacement byte

  // Decoder side
  modport dec (
    output valid,
    output use_b,
    output use_x,
    output disp
  );

  // Pipeline side
  modport pipe (
    input valid,
    input use_b,
    input use_x,
    input disp
  );

endinterface

// File: rtl/mac_top.sv
`timescale 1ns/100ps

// Address arithmetic top
// Decoder feeds the register file and the address pipeline
module mac_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           instr_valid,
  input  logic [mac_cfg_pkg::addr_w-1:0] instr,
  output logic                           addr_valid,
  output logic [mac_cfg_pkg::addr_w-1:0] addr
);

  logic                           wr_en;
  logic [1:0]                     wr_sel;
  logic                           wr_hi;
  logic [mac_cfg_pkg::byte_w-1:0] wr_data;

  logic [mac_cfg_pkg::addr_w-1:0] p;  // Program counter
  logic [mac_cfg_pkg::addr_w-1:0] b;  // Base
  logic [mac_cfg_pkg::addr_w-1:0] x;  // Index

  mac_req_if req_if ();  // Decoder to pipeline

  mac_decode u_decode (
    .instr_valid (instr_valid),
    .instr       (instr),  // Raw word onto the union port
    .req         (req_if.dec),
    .wr_en       (wr_en),
    .wr_sel      (wr_sel),
    .wr_hi       (wr_hi),
    .wr_data     (wr_data)
  );

  mac_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_sel  (wr_sel),
    .wr_hi   (wr_hi),
    .wr_data (wr_data),
    .p       (p),
    .b       (b),
    .x       (x)
  );

  mac_addr_pipe u_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req_if.pipe),
    .p          (p),
    .b          (b),
    .x          (x),
    .addr_valid (addr_valid),
    .addr       (addr)
  );

endmodule

// File: sim/mac_assertions.sv
`timescale 1ns/100ps

// Protocol checks on the address pipeline
module mac_assertions (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           req_valid,   // Decoder strobe
  input logic                           addr_valid,
  input logic [mac_cfg_pkg::addr_w-1:0] addr
);

  // Every request comes out two edges later
  a_latency : assert property (@(posedge clk) disable iff (!rst_n)
    req_valid |-> ##2 addr_valid)
    else $error("request did not produce addr_valid two cycles later");

  // No result without a request two cycles back
  a_no_orphan : assert property (@(posedge clk) disable iff (!rst_n)
    addr_valid |-> $past(req_valid, 2))
    else $error("addr_valid without a matching request");

  // Synchronous reset clears the output strobe
  a_reset_low : assert property (@(posedge clk)
    !rst_n |=> !addr_valid)
    else $error("addr_valid high during reset");

  a_addr_known : assert property (@(posedge clk) disable iff (!rst_n)
    addr_valid |-> !$isunknown(addr))
    else $error("addr unknown while addr_valid is high");

endmodule

// Attached to every pipeline instance
bind mac_addr_pipe mac_assertions u_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .req_valid  (req.valid),
  .addr_valid (addr_valid),
  .addr       (addr)
);

// File: sim/tb_mac_top.sv
`timescale 1ns/100ps

module tb_mac_top;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [15:0] instr;
  logic        addr_valid;
  logic [15:0] addr;

  logic [31:0] lfsr;  // Random source state
  logic [31:0] r;     // Last random draw
  logic [15:0] v;
  logic [15:0] p_m;   // Shadow registers
  logic [15:0] b_m;
  logic [15:0] x_m;
  logic [15:0] exp_addr_q [$];  // Expected addresses in issue order
  int          exp_cyc_q [$];   // Cycle each one is due
  int          cyc = 0;
  int          err_cnt;
  int          chk_cnt;
  int          ref_cnt;
  int          res_cnt;
  int          test_cnt;
  int          test_fail;
  int          test_err0;

  mac_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .addr_valid  (addr_valid),
    .addr        (addr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  always @(posedge clk) cyc <= cyc + 1;  // Edge count

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] acc;
    acc = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      acc  = {acc[30:0], lfsr[0]};
    end
    return acc;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // One word per cycle, 5 ns after the edge
  task automatic drive(input logic [15:0] w);
    @(posedge clk);
    #5;
    instr_valid = 1'b1;
    instr       = w;
  endtask

  task automatic idle();
    @(posedge clk);
    #5;
    instr_valid = 1'b0;
    instr       = '0;
  endtask

  // Memory reference, expected address from the mode rules
  task automatic issue_ref(input logic xb, input logic bb, input logic [7:0] d);
    mac_instr_pkg::instr_u u;
    logic [15:0]           base;
    r          = rand_bits(5);
    u.mem.op   = {1'b0, r[3:0]};  // Any of the 16 memory opcodes
    u.mem.x    = xb;
    u.mem.i    = r[4];            // Indirect has no effect
    u.mem.b    = bb;
    u.mem.disp = d;
    case ({xb, bb})
      2'b00:   base = p_m;
      2'b01:   base = b_m;
      2'b10:   base = x_m;
      default: base = b_m + x_m;
    endcase
    drive(u);
    exp_addr_q.push_back(base + {{8{d[7]}}, d});
    exp_cyc_q.push_back(cyc + 2);  // Visible after the second edge
    ref_cnt++;
  endtask

  task automatic issue_load(input logic [1:0] sel, input logic hi, input logic [7:0] imm);
    mac_instr_pkg::instr_u u;
    u.regld.op  = mac_cfg_pkg::op_ldreg;
    u.regld.sel = sel;
    u.regld.hi  = hi;
    u.regld.imm = imm;
    drive(u);
    if (sel == mac_cfg_pkg::reg_p) p_m = hi ? {imm, p_m[7:0]} : {p_m[15:8], imm};
    if (sel == mac_cfg_pkg::reg_b) b_m = hi ? {imm, b_m[7:0]} : {b_m[15:8], imm};
    if (sel == mac_cfg_pkg::reg_x) x_m = hi ? {imm, x_m[7:0]} : {x_m[15:8], imm};
  endtask

  task automatic set_reg(input logic [1:0] sel, input logic [15:0] val);
    issue_load(sel, 1'b1, val[15:8]);
    issue_load(sel, 1'b0, val[7:0]);
  endtask

  // Opcode above op_ldreg, must do nothing
  task automatic issue_junk();
    r = rand_bits(15);
    drive({1'b1, (r[3:0] == 4'h0) ? 4'h1 : r[3:0], r[14:4]});
  endtask

  task automatic drain();
    int n;
    n = 0;
    idle();
    while (exp_addr_q.size() != 0 && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (exp_addr_q.size() != 0) begin
      $display("Timeout at %0t: %0d addresses never came out", $time, exp_addr_q.size());
      err_cnt++;
      exp_addr_q.delete();
      exp_cyc_q.delete();
    end
    repeat (2) @(negedge clk);  // Room for a stray strobe
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err0) begin
      $display("%s: passed", name);
    end else begin
      test_fail++;
      $display("%s: failed with %0d errors", name, err_cnt - test_err0);
    end
    test_err0 = err_cnt;
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst_n && addr_valid) begin
      res_cnt++;
      if (exp_addr_q.size() == 0) begin
        $display("Unexpected address 0x%0h at %0t with no reference pending", addr, $time);
        err_cnt++;
      end else begin
        check("addr", 32'(addr), 32'(exp_addr_q.pop_front()));
        check("addr_valid cycle", cyc, exp_cyc_q.pop_front());
      end
    end
  end

  initial begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr        = 32'h213c44b4;
    p_m         = '0;
    b_m         = '0;
    x_m         = '0;
    {err_cnt, chk_cnt, ref_cnt, res_cnt} = '0;
    {test_cnt, test_fail, test_err0}     = '0;
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;

    check("addr_valid", 32'(addr_valid), 32'd0);
    for (int m = 0; m < 4; m++) begin
      issue_ref(m[1], m[0], 8'h00);  // All four modes read zero
    end
    drain();
    end_test("reset_state");

    for (int s = 0; s < 3; s++) begin
      for (int h = 0; h < 2; h++) begin
        r = rand_bits(8);
        issue_load(2'(s), h[0], r[7:0]);
        issue_ref(1'b0, 1'b0, 8'h00);
        issue_ref(1'b0, 1'b1, 8'h00);
        issue_ref(1'b1, 1'b0, 8'h00);
      end
    end
    r = rand_bits(9);
    issue_load(mac_cfg_pkg::reg_none, r[8], r[7:0]);  // Dropped load
    issue_junk();
    issue_ref(1'b0, 1'b0, 8'h00);
    issue_ref(1'b0, 1'b1, 8'h00);
    issue_ref(1'b1, 1'b0, 8'h00);
    drain();
    end_test("byte_loads");

    for (int t = 0; t < 4; t++) begin
      case (t)
        0:       v = 16'h00FF;  // Low half carry
        1:       v = 16'hFFFF;  // Wraps both ways
        2:       v = 16'h0100;  // Borrow across halves
        default: v = 16'hFF80;
      endcase
      set_reg(mac_cfg_pkg::reg_p, v);
      set_reg(mac_cfg_pkg::reg_b, v ^ 16'h0001);
      issue_ref(1'b0, 1'b0, 8'h80);
      issue_ref(1'b0, 1'b0, 8'hFF);
      issue_ref(1'b0, 1'b1, 8'h01);
      repeat (6) begin
        r = rand_bits(9);
        issue_ref(1'b0, r[8], r[7:0]);
      end
    end
    drain();
    end_test("signed_disp");

    repeat (16) begin
      r = rand_bits(16);
      set_reg(mac_cfg_pkg::reg_b, r[15:0]);
      r = rand_bits(16);
      set_reg(mac_cfg_pkg::reg_x, r[15:0]);
      r = rand_bits(16);
      issue_ref(1'b1, 1'b1, r[7:0]);
      issue_ref(1'b1, 1'b1, r[15:8]);
    end
    drain();
    end_test("base_plus_index");

    ref_cnt = 0;
    res_cnt = 0;
    repeat (200) begin
      r = rand_bits(12);
      if (r[0]) begin
        issue_ref(r[1], r[2], r[10:3]);
      end else begin
        issue_load(r[2:1], r[3], r[11:4]);  // reg_none included
      end
    end
    drain();
    check("result count", res_cnt, ref_cnt);
    end_test("stream");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fail, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
